// ==== run.sh ====
#!/bin/sh
# Build and run the scaler testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_scaler -f vlog.f -Mdir obj_dir \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_scaler > sim.log 2>&1
! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== scaler_chk.sv ====
/*
	Concurrent assertions on the scaler top level, attached by bind
	run is the internal control bit of the register file
*/

`timescale 1ns/1ps

module scaler_chk
(
	input wire          VID_CLK_IN,
	input wire          rst_n,
	input wire          run,
	input wire          lb_rd,
	input wire [15:0]   lb_dout,
	input wire          vid_cke_out,
	input wire          vid_de_out
);

	// Divider sees run one cycle late
	a_cke_idle: assert property (@(posedge VID_CLK_IN) disable iff (!rst_n)
		!$past(run) |-> vid_cke_out)
		else $error("vid_cke_out low while run is off");

	a_de_cke: assert property (@(posedge VID_CLK_IN) disable iff (!rst_n)
		run && vid_de_out |-> vid_cke_out)
		else $error("vid_de_out high without vid_cke_out");

	// Read data holds once updated
	a_rd_settle: assert property (@(posedge VID_CLK_IN) disable iff (!rst_n)
		lb_rd ##1 !lb_rd |=> $stable(lb_dout))
		else $error("lb_dout changed after the read cycle");

endmodule

// ==== scaler_ctl.sv ====
/*
	Local bus register file on the video clock
	Writes and reads are single-cycle strobes, read data one cycle later
	Unused addresses read as zero, reserved control bits are not stored
	Video parameter writes are also pulsed out for the datapath to capture
*/

`timescale 1ns/1ps

module scaler_ctl
(
	input wire                      VID_CLK_IN,
	input wire                      rst_n,
	input wire                      lb_wr,      // Write strobe
	input wire                      lb_rd,      // Read strobe
	input wire [3:0]                lb_adr,
	input scaler_pkg::ctl_word_t    lb_din,
	output scaler_pkg::ctl_word_t   lb_dout,
	output wire                     run,
	output wire [3:0]               cr,
	output logic [3:0]              vps_idx,
	output logic [15:0]             vps_dat,
	output logic                    vps_vld
);

import scaler_pkg::*;

ctl_word_t          ctl_q;                                  // Control register
logic [len_w-1:0]   vps_q [vps_hact_in:vps_vtotal];         // Read-back copy
logic               is_vps;

	assign is_vps = (lb_adr >= vps_hact_in) && (lb_adr <= vps_vtotal);

	// Control word, strobe and read port
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctl_q <= '0;
			vps_vld <= 1'b0;
			lb_dout <= '0;
		end
		else
		begin
			vps_vld <= 1'b0;
			if (lb_wr)
			begin
				if (lb_adr == reg_ctl)
				begin
					ctl_q.ctl.run <= lb_din.ctl.run;
					ctl_q.ctl.cr <= lb_din.ctl.cr;
					ctl_q.ctl.rsvd <= '0;
				end
				else if (is_vps)
					vps_vld <= 1'b1;                // One-cycle parameter pulse
			end

			// Read data held until the next strobe
			if (lb_rd)
			begin
				if (lb_adr == reg_ctl)
					lb_dout <= ctl_q;
				else if (is_vps)
					lb_dout.len <= vps_q[lb_adr];
				else
					lb_dout <= '0;
			end
		end
	end

	// Parameter data, length view of the bus word
	always_ff @(posedge VID_CLK_IN)
	begin
		if (lb_wr && is_vps)
		begin
			vps_q[lb_adr] <= lb_din.len;
			vps_idx <= lb_adr;
			vps_dat <= lb_din.len;
		end
	end

	assign run = ctl_q.ctl.run;
	assign cr = ctl_q.ctl.cr;

endmodule

// ==== scaler_hor.sv ====
/*
	Horizontal 2x stage, pixel counter runs over the output active width
	Buffer address is the counter halved, so every pixel is sent twice
	Address looks one step ahead to cover the buffer read latency
	pix_out and vld follow de_req by one cke cycle
*/

`timescale 1ns/1ps

module scaler_hor
(
	input wire                              VID_CLK_IN,
	input wire                              rst_n,
	input wire                              clr,
	input wire                              cke,
	input wire                              de_req,
	input wire [scaler_pkg::pix_w-1:0]      rd_dat,
	output wire [scaler_pkg::addr_w-1:0]    rd_adr,
	output logic                            line_done,
	output logic [scaler_pkg::pix_w-1:0]    pix_out,
	output logic                            vld,
	input wire [3:0]                        vps_idx,
	input wire [15:0]                       vps_dat,
	input wire                              vps_vld
);

import scaler_pkg::*;

logic [len_w-1:0]   hact_out;
logic [len_w-1:0]   cnt;            // Output pixel in line
logic [len_w-1:0]   cnt_nxt;
logic               take;
logic               last;
logic               vld_q;          // de_req of the last cke cycle

	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
			hact_out <= '0;
		else if (vps_vld && (vps_idx == vps_hact_out))
			hact_out <= vps_dat;
	end

	assign take = cke && de_req;
	assign last = cnt + len_w'(1) >= hact_out;

	always_comb
	begin
		cnt_nxt = cnt;
		if (take)
			cnt_nxt = last ? '0 : cnt + len_w'(1);
	end

	assign rd_adr = cnt_nxt[addr_w:1];                  // Halved, next pixel

	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
			vld_q <= 1'b0;
			line_done <= 1'b0;
		end
		else if (clr)
		begin
			cnt <= '0;
			vld_q <= 1'b0;
			line_done <= 1'b0;
		end
		else
		begin
			cnt <= cnt_nxt;
			line_done <= take && last;              // One cycle per line
			if (cke)
				vld_q <= de_req;
		end
	end

	assign vld = vld_q && cke;                      // Only on enable cycles

	// Data already valid for cnt
	always_ff @(posedge VID_CLK_IN)
	begin
		if (take)
			pix_out <= rd_dat;
	end

endmodule

// ==== scaler_line.sv ====
/*
	Ping-pong line buffer, two banks of max_line pixels
	A line closes after vps_hact_in pixels or when hs ends it early
	Pixels arriving while the write bank is still full are dropped
	Banks are released in order, read port has one cycle of latency
*/

`timescale 1ns/1ps

module scaler_line
(
	input wire                          VID_CLK_IN,
	input wire                          rst_n,
	input wire                          clr,        // Frame start
	input wire                          cke_in,     // Fresh input sample
	input wire                          run,
	input wire                          hs_in,
	input wire                          de_in,
	input wire [scaler_pkg::pix_w-1:0]  pix_in,
	input wire [scaler_pkg::addr_w:0]   rd_adr,     // {bank, pixel}
	output wire                         line_rdy,
	output wire                         line_bank,
	output logic [scaler_pkg::pix_w-1:0] rd_dat,
	input wire                          bank_free,
	input wire [3:0]                    vps_idx,
	input wire [15:0]                   vps_dat,
	input wire                          vps_vld
);

import scaler_pkg::*;

logic [pix_w-1:0]   mem [0:2*max_line-1];
logic [len_w-1:0]   hact_in;
logic [addr_w-1:0]  wr_cnt;
logic               wr_bank;
logic               rd_ptr;             // Oldest full bank
logic [1:0]         full;
logic               wr_en;
logic               wr_last;
logic               hs_close;

	// Input line width
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
			hact_in <= '0;
		else if (vps_vld && (vps_idx == vps_hact_in))
			hact_in <= vps_dat;
	end

	assign wr_en = cke_in && run && de_in && !full[wr_bank];
	assign wr_last = (len_w'(wr_cnt) + len_w'(1) >= hact_in) ||
		(wr_cnt == addr_w'(max_line - 1));              // Bank capacity
	assign hs_close = cke_in && run && hs_in && (wr_cnt != '0);   // Short line

	// Bank bookkeeping
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			full <= '0;
			wr_bank <= 1'b0;
			rd_ptr <= 1'b0;
			wr_cnt <= '0;
		end
		else if (clr)
		begin
			full <= '0;
			wr_bank <= 1'b0;
			rd_ptr <= 1'b0;
			wr_cnt <= '0;
		end
		else
		begin
			if ((wr_en && wr_last) || hs_close)
			begin
				full[wr_bank] <= 1'b1;              // Hand the line over
				wr_bank <= ~wr_bank;
				wr_cnt <= '0;
			end
			else if (wr_en)
				wr_cnt <= wr_cnt + addr_w'(1);

			// Never the bank being written
			if (bank_free)
			begin
				full[rd_ptr] <= 1'b0;
				rd_ptr <= ~rd_ptr;
			end
		end
	end

	// Pixel store
	always_ff @(posedge VID_CLK_IN)
	begin
		if (wr_en)
			mem[{wr_bank, wr_cnt}] <= pix_in;
		rd_dat <= mem[rd_adr];
	end

	assign line_rdy = |full;
	assign line_bank = rd_ptr;

endmodule

// ==== scaler_pkg.sv ====
/*
	Shared widths, register map and local bus word for the 2x upscaler
	One pixel per clock, 8 bits per component, RGB packed as {r, g, b}
	Line buffer depth caps the input line at max_line pixels
*/

package scaler_pkg;

	// Video widths
	localparam int bpc      = 8;             // Bits per component
	localparam int pix_w    = 3 * bpc;       // Packed RGB pixel
	localparam int max_line = 64;            // Buffer depth per bank
	localparam int addr_w   = 6;             // Line address width
	localparam int len_w    = 16;            // Lengths and counters

	// Local bus register map
	localparam logic [3:0] reg_ctl      = 4'd0;   // Control word
	localparam logic [3:0] vps_hact_in  = 4'd8;   // Input active width
	localparam logic [3:0] vps_hact_out = 4'd9;   // Output active width
	localparam logic [3:0] vps_htotal   = 4'd10;  // Output line total
	localparam logic [3:0] vps_vact_out = 4'd11;  // Output active lines
	localparam logic [3:0] vps_vtotal   = 4'd12;  // Output frame total

	// Control fields, run in bit 0
	typedef struct packed {
		logic [10:0] rsvd;    // Reads as zero
		logic [3:0]  cr;      // Clock ratio
		logic        run;     // Scaler enable
	} ctl_fields_t;

	// One bus word, either a length or the control fields
	typedef union packed {
		logic [len_w-1:0] len;
		ctl_fields_t      ctl;
	} ctl_word_t;

endpackage

// ==== scaler_tg.sv ====
/*
	Output timing generator, active pixels first then blanking in each line
	Counters step only on cke, hs covers the horizontal blanking
	vs_ext is high for the first line of a frame
	Each active line waits at its first pixel until ver_rdy is high
	Blanking must be a few cke cycles long so the line handover can finish
*/

`timescale 1ns/1ps

module scaler_tg
(
	input wire          VID_CLK_IN,
	input wire          rst_n,
	input wire          cke,            // Output pixel enable
	input wire          restart,        // Input vsync edge
	input wire          ver_rdy,        // Line data available
	input wire [3:0]    vps_idx,
	input wire [15:0]   vps_dat,
	input wire          vps_vld,
	output wire         vs_ext,
	output wire         hs,
	output wire         de_req
);

import scaler_pkg::*;

logic [len_w-1:0]   hact;           // Output active width
logic [len_w-1:0]   htotal;
logic [len_w-1:0]   vact;           // Output active lines
logic [len_w-1:0]   vtotal;
logic [len_w-1:0]   h_cnt;
logic [len_w-1:0]   v_cnt;
logic               act_line;
logic               stall;

	// Capture the output geometry
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hact <= '0;
			htotal <= '0;
			vact <= '0;
			vtotal <= '0;
		end
		else if (vps_vld)
		begin
			case (vps_idx)
				vps_hact_out : hact <= vps_dat;
				vps_htotal   : htotal <= vps_dat;
				vps_vact_out : vact <= vps_dat;
				vps_vtotal   : vtotal <= vps_dat;
				default      : ;
			endcase
		end
	end

	// Raster counters
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (restart)
		begin
			h_cnt <= '0;                            // Back to frame start
			v_cnt <= '0;
		end
		else if (cke && !stall)
		begin
			if (h_cnt + len_w'(1) >= htotal)
			begin
				h_cnt <= '0;
				v_cnt <= (v_cnt + len_w'(1) >= vtotal) ? '0 : v_cnt + len_w'(1);
			end
			else
				h_cnt <= h_cnt + len_w'(1);
		end
	end

	assign act_line = v_cnt < vact;
	assign stall = act_line && (h_cnt == '0) && !ver_rdy;    // Hold at line start

	assign de_req = act_line && (h_cnt < hact) && !stall;
	assign hs = (h_cnt >= hact) && (h_cnt < htotal);
	assign vs_ext = (v_cnt == '0) && (vtotal != '0);

endmodule

// ==== scaler_top.sv ====
/*
	2x nearest-neighbour upscaler, one pixel per clock, local bus on VID_CLK_IN
	run low passes the registered input through with one cycle of delay
	run high outputs the scaled picture on internal timing, restarted by input vsync
	Input must be paced so one input line lasts at least two output lines
*/

`timescale 1ns/1ps

module scaler_top
(
	input wire                          VID_CLK_IN,
	input wire                          rst_n,
	input wire                          lb_wr,
	input wire                          lb_rd,
	input wire [3:0]                    lb_adr,
	input scaler_pkg::ctl_word_t        lb_din,
	output scaler_pkg::ctl_word_t       lb_dout,
	input wire                          vid_cke_in,
	input wire                          vid_vs_in,
	input wire                          vid_hs_in,
	input wire [scaler_pkg::bpc-1:0]    vid_r_in,
	input wire [scaler_pkg::bpc-1:0]    vid_g_in,
	input wire [scaler_pkg::bpc-1:0]    vid_b_in,
	input wire                          vid_de_in,
	output wire                         vid_cke_out,
	output wire                         vid_vs_out,
	output wire                         vid_hs_out,
	output wire [scaler_pkg::bpc-1:0]   vid_r_out,
	output wire [scaler_pkg::bpc-1:0]   vid_g_out,
	output wire [scaler_pkg::bpc-1:0]   vid_b_out,
	output wire                         vid_de_out
);

import scaler_pkg::*;

logic               vs_q;           // Input registers
logic               hs_q;
logic               de_q;
logic [bpc-1:0]     r_q;
logic [bpc-1:0]     g_q;
logic [bpc-1:0]     b_q;
logic               cke_q;          // New sample in registers
logic               vs_d;
wire                vs_re;
logic [3:0]         cke_cnt;
logic               cke;
wire                run;
wire [3:0]          cr;
wire [3:0]          vps_idx;
wire [15:0]         vps_dat;
wire                vps_vld;
wire                vs_ext;
wire                hs_tg;
wire                de_req;
wire                line_rdy;
wire                line_bank;
wire [pix_w-1:0]    rd_dat;
wire                ver_rdy;
wire                rd_bank;
wire                bank_free;
wire [addr_w-1:0]   hor_rd_adr;
wire                line_done;
wire [pix_w-1:0]    hor_pix;
wire                hor_vld;

	// Sync and enable registers
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vs_q <= 1'b0;
			hs_q <= 1'b0;
			de_q <= 1'b0;
			cke_q <= 1'b0;
			vs_d <= 1'b0;
		end
		else
		begin
			if (vid_cke_in)
			begin
				vs_q <= vid_vs_in;
				hs_q <= vid_hs_in;
				de_q <= vid_de_in;
			end
			cke_q <= vid_cke_in;
			vs_d <= vs_q;                           // Edge detector delay
		end
	end

	// Pixel registers
	always_ff @(posedge VID_CLK_IN)
	begin
		if (vid_cke_in)
		begin
			r_q <= vid_r_in;
			g_q <= vid_g_in;
			b_q <= vid_b_in;
		end
	end

	assign vs_re = vs_q && !vs_d;                   // Frame start pulse

	// Output clock enable divider
	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cke <= 1'b1;
			cke_cnt <= '0;
		end
		else if (run)
		begin
			if (cke_cnt == '0)
			begin
				cke <= 1'b1;
				cke_cnt <= (cr == '0) ? '0 : cr - 4'd1;    // Ratio 0 acts as 1
			end
			else
			begin
				cke <= 1'b0;
				cke_cnt <= cke_cnt - 4'd1;
			end
		end
		else
		begin
			cke <= 1'b1;                            // Free running when idle
			cke_cnt <= '0;
		end
	end

	scaler_ctl ctl0
	(
		.VID_CLK_IN (VID_CLK_IN),
		.rst_n      (rst_n),
		.lb_wr      (lb_wr),
		.lb_rd      (lb_rd),
		.lb_adr     (lb_adr),
		.lb_din     (lb_din),
		.lb_dout    (lb_dout),
		.run        (run),
		.cr         (cr),
		.vps_idx    (vps_idx),
		.vps_dat    (vps_dat),
		.vps_vld    (vps_vld)
	);

	scaler_tg tg0
	(
		.VID_CLK_IN (VID_CLK_IN),
		.rst_n      (rst_n),
		.cke        (cke),
		.restart    (vs_re),
		.ver_rdy    (ver_rdy),
		.vps_idx    (vps_idx),
		.vps_dat    (vps_dat),
		.vps_vld    (vps_vld),
		.vs_ext     (vs_ext),
		.hs         (hs_tg),
		.de_req     (de_req)
	);

	scaler_line line0
	(
		.VID_CLK_IN (VID_CLK_IN),
		.rst_n      (rst_n),
		.clr        (vs_re),
		.cke_in     (cke_q),
		.run        (run),
		.hs_in      (hs_q),
		.de_in      (de_q),
		.pix_in     ({r_q, g_q, b_q}),
		.rd_adr     ({rd_bank, hor_rd_adr}),        // Bank from vertical stage
		.line_rdy   (line_rdy),
		.line_bank  (line_bank),
		.rd_dat     (rd_dat),
		.bank_free  (bank_free),
		.vps_idx    (vps_idx),
		.vps_dat    (vps_dat),
		.vps_vld    (vps_vld)
	);

	scaler_ver ver0
	(
		.VID_CLK_IN (VID_CLK_IN),
		.rst_n      (rst_n),
		.clr        (vs_re),
		.run        (run),
		.line_rdy   (line_rdy),
		.line_bank  (line_bank),
		.line_done  (line_done),
		.ver_rdy    (ver_rdy),
		.rd_bank    (rd_bank),
		.bank_free  (bank_free)
	);

	scaler_hor hor0
	(
		.VID_CLK_IN (VID_CLK_IN),
		.rst_n      (rst_n),
		.clr        (vs_re),
		.cke        (cke),
		.de_req     (de_req),
		.rd_dat     (rd_dat),
		.rd_adr     (hor_rd_adr),
		.line_done  (line_done),
		.pix_out    (hor_pix),
		.vld        (hor_vld),
		.vps_idx    (vps_idx),
		.vps_dat    (vps_dat),
		.vps_vld    (vps_vld)
	);

	// Bypass mux
	assign vid_cke_out = cke;
	assign vid_vs_out = run ? vs_ext : vs_q;
	assign vid_hs_out = run ? hs_tg : hs_q;
	assign vid_r_out = run ? hor_pix[2*bpc +: bpc] : r_q;
	assign vid_g_out = run ? hor_pix[bpc +: bpc] : g_q;
	assign vid_b_out = run ? hor_pix[0 +: bpc] : b_q;
	assign vid_de_out = run ? hor_vld : de_q;      // Scaled pixel strobe

endmodule

// ==== scaler_ver.sv ====
/*
	Vertical 2x stage, each buffered line is shown on two output lines
	ver_rdy rises one cycle after a bank is taken, so the read bank settles
	A bank is freed after its second line_done
*/

`timescale 1ns/1ps

module scaler_ver
(
	input wire      VID_CLK_IN,
	input wire      rst_n,
	input wire      clr,
	input wire      run,
	input wire      line_rdy,
	input wire      line_bank,
	input wire      line_done,      // End of one output line
	output logic    ver_rdy,
	output logic    rd_bank,
	output logic    bank_free
);

logic   busy;           // Line held
logic   rep;            // Second read-out

	always_ff @(posedge VID_CLK_IN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			ver_rdy <= 1'b0;
			rep <= 1'b0;
			rd_bank <= 1'b0;
			bank_free <= 1'b0;
		end
		else if (clr || !run)
		begin
			busy <= 1'b0;
			ver_rdy <= 1'b0;
			rep <= 1'b0;
			bank_free <= 1'b0;
		end
		else
		begin
			bank_free <= 1'b0;
			// Skip while the freed bank still looks full
			if (!busy && !bank_free && line_rdy)
			begin
				busy <= 1'b1;
				rd_bank <= line_bank;
				rep <= 1'b0;
			end
			else if (busy && !ver_rdy)
				ver_rdy <= 1'b1;
			else if (ver_rdy && line_done)
			begin
				if (rep)
				begin
					busy <= 1'b0;
					ver_rdy <= 1'b0;
					bank_free <= 1'b1;          // Line used twice
				end
				else
					rep <= 1'b1;
			end
		end
	end

endmodule

// ==== tb_scaler.sv ====
/*
	Directed testbench for the 2x upscaler top level
	Inputs change on the rising edge, outputs are sampled on the falling edge
	Scaled frames use 8x4 input pixels, one sample every 4 clocks
	Pixel data from a Galois LFSR, one step per bit taken
*/

`timescale 1ns/1ps

module tb_scaler;

import scaler_pkg::*;

localparam int tmo = 3000;          // Cycles per wait loop

logic           clk;
logic           rst_n;
logic           lb_wr;
logic           lb_rd;
logic [3:0]     lb_adr;
ctl_word_t      lb_din;
ctl_word_t      lb_dout;
logic           vid_cke_in;
logic           vid_vs_in;
logic           vid_hs_in;
logic [7:0]     vid_r_in;
logic [7:0]     vid_g_in;
logic [7:0]     vid_b_in;
logic           vid_de_in;
wire            vid_cke_out;
wire            vid_vs_out;
wire            vid_hs_out;
wire [7:0]      vid_r_out;
wire [7:0]      vid_g_out;
wire [7:0]      vid_b_out;
wire            vid_de_out;
logic [31:0]    lfsr;
int             errors;
int             checks;
logic [23:0]    in_pix [0:3][0:7];  // Current input frame
logic [23:0]    out_pix [0:127];    // Collected output frame

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	scaler_top dut0
	(
		.VID_CLK_IN (clk),
		.rst_n      (rst_n),
		.lb_wr      (lb_wr),
		.lb_rd      (lb_rd),
		.lb_adr     (lb_adr),
		.lb_din     (lb_din),
		.lb_dout    (lb_dout),
		.vid_cke_in (vid_cke_in),
		.vid_vs_in  (vid_vs_in),
		.vid_hs_in  (vid_hs_in),
		.vid_r_in   (vid_r_in),
		.vid_g_in   (vid_g_in),
		.vid_b_in   (vid_b_in),
		.vid_de_in  (vid_de_in),
		.vid_cke_out(vid_cke_out),
		.vid_vs_out (vid_vs_out),
		.vid_hs_out (vid_hs_out),
		.vid_r_out  (vid_r_out),
		.vid_g_out  (vid_g_out),
		.vid_b_out  (vid_b_out),
		.vid_de_out (vid_de_out)
	);

	bind scaler_top scaler_chk chk0
	(
		.VID_CLK_IN (VID_CLK_IN),
		.rst_n      (rst_n),
		.run        (run),           // Internal control bit
		.lb_rd      (lb_rd),
		.lb_dout    (lb_dout),
		.vid_cke_out(vid_cke_out),
		.vid_de_out (vid_de_out)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// n bits, one LFSR step each
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic bus_write(input logic [3:0] adr, input ctl_word_t w);
		@(posedge clk);
		lb_wr <= 1'b1;
		lb_adr <= adr;
		lb_din <= w;
		@(posedge clk);
		lb_wr <= 1'b0;
	endtask

	// Data sampled one cycle after the strobe
	task automatic bus_read(input logic [3:0] adr, output ctl_word_t w);
		@(posedge clk);
		lb_rd <= 1'b1;
		lb_adr <= adr;
		@(posedge clk);
		lb_rd <= 1'b0;
		@(negedge clk);
		w = lb_dout;
	endtask

	task automatic test_reset();
		ctl_word_t w;
		@(negedge clk);
		check_hex("vid_cke_out", vid_cke_out, 1);
		bus_read(reg_ctl, w);
		check_hex("lb_dout", w.len, 0);
	endtask

	task automatic test_regs();
		logic [3:0] adr [0:4];
		logic [15:0] val [0:4];
		ctl_word_t w;
		ctl_word_t e;
		adr = '{vps_hact_in, vps_hact_out, vps_htotal, vps_vact_out, vps_vtotal};
		val = '{16'd8, 16'd16, 16'd24, 16'd8, 16'd12};   // 8x4 in, 16x8 out
		for (int i = 0; i < 5; i++)
		begin
			w.len = val[i];
			bus_write(adr[i], w);
		end
		w.len = 16'hffea;                       // Reserved bits set, run off
		bus_write(reg_ctl, w);
		for (int i = 0; i < 5; i++)
		begin
			bus_read(adr[i], w);
			check_hex("lb_dout", w.len, val[i]);
		end
		e.ctl.rsvd = '0;
		e.ctl.cr = 4'd5;
		e.ctl.run = 1'b0;
		bus_read(reg_ctl, w);
		check_hex("lb_dout", w.len, e.len);
	endtask

	task automatic test_bypass();
		logic [31:0] v;
		logic [31:0] c;
		logic [26:0] exp;                       // {vs, hs, de, r, g, b}
		logic cke;
		for (int i = 0; i < 40; i++)
		begin
			take_bits(27, v);
			take_bits(2, c);
			cke = (i == 0) || (c != 0);         // Mostly enabled
			@(posedge clk);
			vid_cke_in <= cke;
			{vid_vs_in, vid_hs_in, vid_de_in, vid_r_in, vid_g_in, vid_b_in} <= v[26:0];
			@(negedge clk);
			if (i > 0)
			begin
				check_hex("vid_r_out", vid_r_out, exp[23:16]);
				check_hex("vid_g_out", vid_g_out, exp[15:8]);
				check_hex("vid_b_out", vid_b_out, exp[7:0]);
				check_hex("vid_vs_out", vid_vs_out, exp[26]);
				check_hex("vid_hs_out", vid_hs_out, exp[25]);
				check_hex("vid_de_out", vid_de_out, exp[24]);
			end
			if (cke)
				exp = v[26:0];
		end
		@(posedge clk);
		{vid_cke_in, vid_vs_in, vid_hs_in, vid_de_in} <= '0;
	endtask

	task automatic test_cke();
		ctl_word_t w;
		int last;
		int pulses;
		w = '0;
		w.ctl.run = 1'b1;
		w.ctl.cr = 4'd3;
		bus_write(reg_ctl, w);
		repeat (4) @(negedge clk);
		last = -1;
		pulses = 0;
		for (int i = 0; i < 30; i++)
		begin
			@(negedge clk);
			if (vid_cke_out)
			begin
				if (last >= 0)
					check_hex("vid_cke_out period", i - last, 3);
				last = i;
				pulses++;
			end
		end
		check_hex("vid_cke_out pulses", pulses, 10);
		w.ctl.run = 1'b0;
		bus_write(reg_ctl, w);
		repeat (2) @(negedge clk);
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			check_hex("vid_cke_out", vid_cke_out, 1);
		end
	endtask

	// One input sample, held for 4 clocks
	task automatic send_slot(input logic vs, input logic hs, input logic de, input logic [23:0] p);
		@(posedge clk);
		vid_cke_in <= 1'b1;
		vid_vs_in <= vs;
		vid_hs_in <= hs;
		vid_de_in <= de;
		{vid_r_in, vid_g_in, vid_b_in} <= p;
		repeat (3)
		begin
			@(posedge clk);
			vid_cke_in <= 1'b0;
		end
	endtask

	task automatic drive_frame();
		send_slot(1'b0, 1'b0, 1'b0, '0);
		send_slot(1'b1, 1'b0, 1'b0, '0);        // Frame start
		send_slot(1'b0, 1'b0, 1'b0, '0);
		for (int l = 0; l < 4; l++)
		begin
			for (int p = 0; p < 8; p++)
				send_slot(1'b0, 1'b0, 1'b1, in_pix[l][p]);
			repeat (12)
				send_slot(1'b0, 1'b1, 1'b0, '0);    // Long blanking
		end
	endtask

	// Pixels until the frame wraps to its next vsync
	task automatic collect_frame();
		int n;
		int cyc;
		int rises;
		logic vs_prev;
		n = 0;
		cyc = 0;
		rises = 0;
		vs_prev = 1'b1;
		while (!(n == 128 && rises > 0) && cyc < tmo)
		begin
			@(negedge clk);
			cyc++;
			if (n > 0 && vid_vs_out && !vs_prev)
				rises++;
			vs_prev = vid_vs_out;
			if (vid_de_out)
			begin
				if (n == 0)
					check_hex("vid_vs_out", vid_vs_out, 1);
				if (n < 128)
					out_pix[n] = {vid_r_out, vid_g_out, vid_b_out};
				else
				begin
					errors++;
					$display("Extra output pixel after the full scaled frame at %0t", $time);
				end
				n++;
			end
		end
		if (cyc >= tmo)
		begin
			errors++;
			$display("Timeout waiting for the scaled frame, %0d of 128 pixels seen", n);
		end
		else
			check_hex("vid_vs_out rises", rises, 1);
		for (int i = 0; i < n && i < 128; i++)
			check_hex("vid_rgb_out", out_pix[i], in_pix[i / 32][(i % 16) / 2]);
	endtask

	task automatic test_frame();
		logic [31:0] v;
		for (int l = 0; l < 4; l++)
			for (int p = 0; p < 8; p++)
			begin
				take_bits(24, v);
				in_pix[l][p] = v[23:0];
			end
		fork
			drive_frame();
			collect_frame();
		join
	endtask

	initial
	begin
		ctl_word_t w;
		rst_n = 1'b0;
		lb_wr = 1'b0;
		lb_rd = 1'b0;
		lb_adr = '0;
		lb_din = '0;
		vid_cke_in = 1'b0;
		vid_vs_in = 1'b0;
		vid_hs_in = 1'b0;
		vid_de_in = 1'b0;
		vid_r_in = '0;
		vid_g_in = '0;
		vid_b_in = '0;
		lfsr = 32'h552885a7;
		errors = 0;
		checks = 0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_regs();
		test_bypass();
		test_cke();
		w = '0;
		w.ctl.run = 1'b1;
		w.ctl.cr = 4'd1;                        // Full output rate
		bus_write(reg_ctl, w);
		test_frame();
		repeat (20) @(posedge clk);
		test_frame();                           // Fresh data, restart
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
scaler_pkg.sv
scaler_ctl.sv
scaler_tg.sv
scaler_line.sv
scaler_ver.sv
scaler_hor.sv
scaler_top.sv
scaler_chk.sv
tb_scaler.sv
